//--- design/loader_config.svh
// Loader widths, autotype timing and page-zero pointer addresses, included by RTL and testbench
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// ====================
// Widths
`define LDR_ADDR_W 16
`define LDR_DATA_W 8

// Clock cycles between two autotype key events
`define LDR_KEY_STEP_CYCLES 200

// ====================
// BASIC pointers in page zero
`define LDR_PTR_TXT_LO 8'h2B
`define LDR_PTR_TXT_HI 8'h2C
`define LDR_PTR_SAVE_LO 8'hAC
`define LDR_PTR_SAVE_HI 8'hAD
// VAR, ARY, STR and LOAD_END all point at the end of the program
`define LDR_PTR_END_LO_SET 8'h2D, 8'h2F, 8'h31, 8'hAE
`define LDR_PTR_END_HI_SET 8'h2E, 8'h30, 8'h32, 8'hAF
`define LDR_MEMINIT_LAST 8'hFF

`endif

//--- design/loader_pkg.sv
// Types shared by the program loader blocks and its testbench, compiled before any module
`default_nettype none
`include "loader_config.svh"

package loader_pkg;

	// ====================
	// Host download beat, valid while strobe is high
	typedef struct packed {
		logic                   strobe;
		logic [`LDR_ADDR_W-1:0] offset;
		logic [`LDR_DATA_W-1:0] data;
	} dl_beat_t;

	// One byte write towards main memory
	typedef struct packed {
		logic [`LDR_ADDR_W-1:0] addr;
		logic [`LDR_DATA_W-1:0] data;
	} mem_req_t;

	// PS/2 key event, a new event is flagged by a change of toggle
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

	// ====================
	// Download sequencer states
	typedef enum logic [2:0] {
		LD_IDLE,
		LD_HEADER,
		LD_DATA,
		LD_MEMINIT,
		LD_DONE
	} load_state_e;

endpackage

`default_nettype wire

//--- design/mem_write_port.sv
// Single-entry memory write buffer, releases its byte in the next free slot of the core
`timescale 1ns/1ps
`default_nettype none

module mem_write_port (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 wr_req_i,
	input  loader_pkg::mem_req_t wr_data_i,
	input  logic                 slot_i,
	output logic                 busy_o,
	output loader_pkg::mem_req_t mem_req_o,
	output logic                 mem_we_o
);

	// slot_i from the previous cycle
	logic slot_d;

	// ====================
	// Slot just freed by the core and a byte is waiting
	assign mem_we_o = busy_o && slot_d && !slot_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			busy_o <= 1'b0;
			slot_d <= 1'b0;
		end else begin
			slot_d <= slot_i;
			if (wr_req_i) begin
				busy_o <= 1'b1;
			end else if (mem_we_o) begin
				// Drops the cycle after the write strobe
				busy_o <= 1'b0;
			end
		end
	end

	// ====================
	// Address and data stay put from capture until the write is done
	always_ff @(posedge clk_sys) begin
		if (wr_req_i) begin
			mem_req_o <= wr_data_i;
		end
	end

endmodule

`default_nettype wire

//--- design/load_sequencer.sv
// Download sequencer, turns a PRG byte stream into memory writes and then sets up BASIC pointers
`timescale 1ns/1ps
`default_nettype none
`include "loader_config.svh"

module load_sequencer (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 dl_active_i,
	input  loader_pkg::dl_beat_t dl_beat_i,
	input  logic                 busy_i,
	output logic                 wr_req_o,
	output loader_pkg::mem_req_t wr_data_o,
	output logic                 dl_wait_o,
	output logic                 start_o
);
	import loader_pkg::*;

	// Start of BASIC text after a cold start, TXT keeps this value
	localparam logic [`LDR_ADDR_W-1:0] BASIC_START = 'h0801;

	load_state_e            state;
	logic [`LDR_ADDR_W-1:0] wr_ptr;
	logic [`LDR_ADDR_W-1:0] end_addr;
	logic [7:0]             zp_addr;
	logic                   busy_d;
	logic                   seen_busy;
	logic                   port_free;
	logic                   zp_hit;
	logic [`LDR_DATA_W-1:0] zp_byte;

	// Port idle now and a cycle ago, with no request in flight
	assign port_free = !busy_i && !busy_d && !wr_req_o;

	// ====================
	// Page-zero pointer table
	always_comb begin
		zp_hit  = 1'b1;
		zp_byte = '0;
		case (zp_addr)
			`LDR_PTR_TXT_LO:                    zp_byte = BASIC_START[7:0];
			`LDR_PTR_TXT_HI:                    zp_byte = BASIC_START[15:8];
			`LDR_PTR_SAVE_LO, `LDR_PTR_SAVE_HI: zp_byte = '0;
			`LDR_PTR_END_LO_SET:                zp_byte = end_addr[7:0];
			`LDR_PTR_END_HI_SET:                zp_byte = end_addr[15:8];
			default:                            zp_hit  = 1'b0;
		endcase
	end

	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state     <= LD_IDLE;
			wr_req_o  <= 1'b0;
			dl_wait_o <= 1'b0;
			start_o   <= 1'b0;
			seen_busy <= 1'b0;
			busy_d    <= 1'b0;
			zp_addr   <= '0;
		end else begin
			wr_req_o <= 1'b0;
			start_o  <= 1'b0;
			busy_d   <= busy_i;

			// Host stays on hold until the port has taken the byte and retired it
			if (dl_wait_o) begin
				if (busy_i) begin
					seen_busy <= 1'b1;
				end else if (seen_busy) begin
					seen_busy <= 1'b0;
					dl_wait_o <= 1'b0;
				end
			end

			case (state)
				LD_IDLE: begin
					if (dl_active_i) begin
						state <= LD_HEADER;
					end
				end
				LD_HEADER: begin
					if (!dl_active_i) begin
						state   <= LD_MEMINIT;
						zp_addr <= '0;
					end else if (dl_beat_i.strobe && dl_beat_i.offset == '0) begin
						wr_ptr[7:0]   <= dl_beat_i.data;
						end_addr[7:0] <= dl_beat_i.data;
					end else if (dl_beat_i.strobe && dl_beat_i.offset == 1) begin
						wr_ptr[15:8]   <= dl_beat_i.data;
						end_addr[15:8] <= dl_beat_i.data;
						state          <= LD_DATA;
					end
				end
				LD_DATA: begin
					if (!dl_active_i) begin
						state   <= LD_MEMINIT;
						zp_addr <= '0;
					end else if (dl_beat_i.strobe) begin
						wr_req_o  <= 1'b1;
						wr_data_o <= '{addr: wr_ptr, data: dl_beat_i.data};
						wr_ptr    <= wr_ptr + 1'b1;
						end_addr  <= end_addr + 1'b1;
						dl_wait_o <= 1'b1;
						seen_busy <= 1'b0;
					end
				end
				LD_MEMINIT: begin
					// One address per free slot, writes only at pointer bytes
					if (port_free) begin
						if (zp_hit) begin
							wr_req_o  <= 1'b1;
							wr_data_o <= '{addr: `LDR_ADDR_W'(zp_addr), data: zp_byte};
						end
						if (zp_addr == `LDR_MEMINIT_LAST) begin
							state <= LD_DONE;
						end else begin
							zp_addr <= zp_addr + 1'b1;
						end
					end
				end
				LD_DONE: begin
					// Last pointer byte must be in memory before RUN is typed
					if (port_free) begin
						start_o <= 1'b1;
						state   <= LD_IDLE;
					end
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/key_injector.sv
// Keyboard path to the core, passes live keys and types R U N RETURN after a program load
`timescale 1ns/1ps
`default_nettype none
`include "loader_config.svh"

module key_injector (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   start_i,
	input  loader_pkg::key_event_t ps2_key_i,
	output loader_pkg::key_event_t key_o
);

	localparam int STEP_W = $clog2(`LDR_KEY_STEP_CYCLES);
	localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`LDR_KEY_STEP_CYCLES - 1);
	// Press and release for each of the four keys
	localparam int EVT_COUNT = 8;

	// PS/2 set 2 codes for R, U, N and RETURN
	localparam logic [7:0] RUN_CODES [4] = '{8'h2D, 8'h3C, 8'h31, 8'h5A};

	logic              active;
	logic [STEP_W-1:0] step_cnt;
	logic [3:0]        evt_idx;

	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active   <= 1'b0;
			step_cnt <= '0;
			evt_idx  <= '0;
			key_o    <= '0;
		end else if (start_i) begin
			active   <= 1'b1;
			step_cnt <= '0;
			evt_idx  <= '0;
		end else if (active) begin
			if (step_cnt == STEP_LAST) begin
				step_cnt <= '0;
				if (evt_idx == 4'(EVT_COUNT)) begin
					// One quiet step after the last release, then live keys again
					active <= 1'b0;
				end else begin
					// Even index is the press, odd index the release
					key_o.toggle   <= ~key_o.toggle;
					key_o.pressed  <= ~evt_idx[0];
					key_o.extended <= 1'b0;
					key_o.code     <= RUN_CODES[evt_idx[2:1]];
					evt_idx        <= evt_idx + 1'b1;
				end
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end else begin
			// Normal operation
			key_o <= ps2_key_i;
		end
	end

endmodule

`default_nettype wire

//--- design/prg_loader_top.sv
// Program injection top level, connects the host download and keyboard to the core memory port
`timescale 1ns/1ps
`default_nettype none

module prg_loader_top (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	// Host download stream
	input  logic                   dl_active_i,
	input  loader_pkg::dl_beat_t   dl_beat_i,
	output logic                   dl_wait_o,
	// Core memory slot
	input  logic                   slot_i,
	output loader_pkg::mem_req_t   mem_req_o,
	output logic                   mem_we_o,
	// Keyboard path
	input  loader_pkg::key_event_t ps2_key_i,
	output loader_pkg::key_event_t key_o
);
	import loader_pkg::*;

	logic     wr_req;
	mem_req_t wr_data;
	logic     wr_busy;
	logic     autotype_start;

	// ====================
	// Header capture, data writes and pointer init
	load_sequencer u_seq (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_beat_i   (dl_beat_i),
		.busy_i      (wr_busy),
		.wr_req_o    (wr_req),
		.wr_data_o   (wr_data),
		.dl_wait_o   (dl_wait_o),
		.start_o     (autotype_start)
	);

	// Single-entry write buffer in front of the memory slot
	mem_write_port u_port (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.wr_req_i  (wr_req),
		.wr_data_i (wr_data),
		.slot_i    (slot_i),
		.busy_o    (wr_busy),
		.mem_req_o (mem_req_o),
		.mem_we_o  (mem_we_o)
	);

	// Keyboard pass-through and RUN autotype
	key_injector u_keys (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.start_i   (autotype_start),
		.ps2_key_i (ps2_key_i),
		.key_o     (key_o)
	);

endmodule

`default_nettype wire

//--- sim/tb_prg_loader.sv
// Self-checking testbench for prg_loader_top, run as the simulation top through sim.f
`timescale 1ns/1ps
`default_nettype none
`include "loader_config.svh"

module tb_prg_loader;
	import loader_pkg::*;

	localparam int NUM_BYTES = 20;
	localparam logic [`LDR_ADDR_W-1:0] LOAD_ADDR = 16'h0801;
	localparam logic [`LDR_ADDR_W-1:0] END_ADDR = LOAD_ADDR + 16'(NUM_BYTES);
	// TXT, SAVE and the four end pointers, two bytes each
	localparam int PZ_WRITES = 12;
	localparam int STALL_AT = 10;
	localparam int STALL_CYCLES = 50;
	localparam int DL_CYCLES = (NUM_BYTES + 2) * 24 + STALL_CYCLES;
	localparam int INIT_CYCLES = 256 + PZ_WRITES * 24;
	localparam int KEY_CYCLES = 10 * `LDR_KEY_STEP_CYCLES + 64;
	localparam int TIMEOUT = 4 * (DL_CYCLES + INIT_CYCLES + KEY_CYCLES + 64);

	logic clk_sys = 1'b0;
	logic reset_n;
	logic dl_active_i;
	dl_beat_t dl_beat_i;
	logic dl_wait_o;
	logic slot_i;
	mem_req_t mem_req_o;
	logic mem_we_o;
	key_event_t ps2_key_i;
	key_event_t key_o;

	integer seed;
	logic [31:0] rnd;
	logic [7:0] mem [0:65535];
	mem_req_t wr_log [0:63];
	logic [7:0] dl_bytes [0:NUM_BYTES-1];
	int wr_count = 0;
	int cyc = 0;
	int evt_count = 0;
	int last_evt = 0;
	int proto_errs = 0;
	int data_errs = 0;
	int key_errs = 0;
	logic key_tgl_d = 1'b0;
	logic force_busy = 1'b0;
	logic pass_chk = 1'b0;
	logic hdr_chk = 1'b0;
	logic in_data = 1'b0;
	logic stall_chk = 1'b0;
	logic auto_chk = 1'b0;
	logic data_beat;

	assign data_beat = dl_beat_i.strobe && in_data;

	always #4 clk_sys = ~clk_sys;

	prg_loader_top i_dut (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_beat_i   (dl_beat_i),
		.dl_wait_o   (dl_wait_o),
		.slot_i      (slot_i),
		.mem_req_o   (mem_req_o),
		.mem_we_o    (mem_we_o),
		.ps2_key_i   (ps2_key_i),
		.key_o       (key_o)
	);

	// ====================
	// Protocol assertions
	a_slot_edge: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |-> (!slot_i && $past(slot_i)))
		else begin proto_errs++; $display("ERR %0t: write outside a freed slot", $time); end
	a_hdr_no_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		hdr_chk |-> !dl_wait_o)
		else begin proto_errs++; $display("ERR %0t: wait raised by a header beat", $time); end
	a_data_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$past(data_beat) |-> dl_wait_o)
		else begin proto_errs++; $display("ERR %0t: no wait after a data beat", $time); end
	a_stall: assert property (@(posedge clk_sys) disable iff (!reset_n)
		stall_chk |-> (dl_wait_o && !mem_we_o))
		else begin proto_errs++; $display("ERR %0t: wait dropped while slots busy", $time); end
	a_pass: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(pass_chk && $past(pass_chk)) |-> (key_o == $past(ps2_key_i)))
		else begin key_errs++; $display("ERR %0t: key_o does not follow live key", $time); end

	// ====================
	// Slot pattern and live key stimulus
	always @(posedge clk_sys) begin
		#1;
		rnd = $random(seed);
		slot_i = force_busy | rnd[0];
		if (pass_chk) begin
			ps2_key_i = key_event_t'(rnd[18:8]);
		end
	end

	// Memory model with write log
	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
		if (reset_n && mem_we_o) begin
			mem[mem_req_o.addr] <= mem_req_o.data;
			if (wr_count < 64) begin
				wr_log[wr_count] <= mem_req_o;
			end
			wr_count <= wr_count + 1;
		end
		if (cyc >= TIMEOUT) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Scan code of key event idx, R U N RETURN
	function automatic logic [7:0] run_code(input int idx);
		case (idx / 2)
			0: return 8'h2D;
			1: return 8'h3C;
			2: return 8'h31;
			default: return 8'h5A;
		endcase
	endfunction

	// Autotype monitor
	always @(posedge clk_sys) begin
		key_tgl_d <= key_o.toggle;
		if (auto_chk && key_o.toggle != key_tgl_d) begin
			evt_count <= evt_count + 1;
			last_evt  <= cyc;
			if (evt_count == 0) begin
				assert (wr_count == NUM_BYTES + PZ_WRITES)
					else begin key_errs++; $display("ERR %0t: keys before pointer init", $time); end
			end else begin
				assert (cyc - last_evt == `LDR_KEY_STEP_CYCLES)
					else begin key_errs++; $display("ERR %0t: key step %0d cycles", $time, cyc - last_evt); end
			end
			assert (evt_count < 8)
				else begin key_errs++; $display("Extra key event after RETURN release at %0t", $time); end
			if (evt_count < 8) begin
				assert (key_o.code == run_code(evt_count) && key_o.pressed == !evt_count[0]
					&& !key_o.extended)
					else begin key_errs++; $display("ERR %0t: key event %0d wrong", $time, evt_count); end
			end
		end
	end

	// Expected page-zero write idx, ascending address order
	function automatic mem_req_t pz_expect(input int idx);
		case (idx)
			0: return '{addr: 16'h002B, data: 8'h01};
			1: return '{addr: 16'h002C, data: 8'h08};
			2: return '{addr: 16'h002D, data: END_ADDR[7:0]};
			3: return '{addr: 16'h002E, data: END_ADDR[15:8]};
			4: return '{addr: 16'h002F, data: END_ADDR[7:0]};
			5: return '{addr: 16'h0030, data: END_ADDR[15:8]};
			6: return '{addr: 16'h0031, data: END_ADDR[7:0]};
			7: return '{addr: 16'h0032, data: END_ADDR[15:8]};
			8: return '{addr: 16'h00AC, data: 8'h00};
			9: return '{addr: 16'h00AD, data: 8'h00};
			10: return '{addr: 16'h00AE, data: END_ADDR[7:0]};
			default: return '{addr: 16'h00AF, data: END_ADDR[15:8]};
		endcase
	endfunction

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	// Host side, one beat then one idle cycle
	task automatic send_beat(input logic [`LDR_ADDR_W-1:0] off, input logic [`LDR_DATA_W-1:0] val);
		tick();
		while (dl_wait_o) begin
			tick();
		end
		dl_beat_i = '{strobe: 1'b1, offset: off, data: val};
		tick();
		dl_beat_i = '0;
		tick();
	endtask

	task automatic check_log();
		mem_req_t exp;
		assert (wr_count == NUM_BYTES + PZ_WRITES)
			else begin data_errs++; $display("ERR %0t: %0d writes seen", $time, wr_count); end
		for (int k = 0; k < NUM_BYTES + PZ_WRITES && k < wr_count; k++) begin
			if (k < NUM_BYTES) begin
				exp = '{addr: LOAD_ADDR + 16'(k), data: dl_bytes[k]};
			end else begin
				exp = pz_expect(k - NUM_BYTES);
			end
			assert (wr_log[k] == exp)
				else begin data_errs++; $display("ERR %0t: write %0d is %h", $time, k, wr_log[k]); end
		end
		for (int k = 0; k < NUM_BYTES; k++) begin
			assert (mem[LOAD_ADDR + 16'(k)] == dl_bytes[k])
				else begin data_errs++; $display("ERR %0t: memory byte %0d", $time, k); end
		end
	endtask

	// ====================
	initial begin
		seed = 32'h9ba68961;
		reset_n = 1'b0;
		dl_active_i = 1'b0;
		dl_beat_i = '0;
		slot_i = 1'b0;
		ps2_key_i = '0;
		for (int k = 0; k < NUM_BYTES; k++) begin
			dl_bytes[k] = 8'($random(seed));
		end
		repeat (8) tick();
		reset_n = 1'b1;
		tick();
		assert (!mem_we_o && !dl_wait_o)
			else begin proto_errs++; $display("ERR %0t: outputs active after reset", $time); end
		pass_chk <= 1'b1;
		repeat (20) tick();

		dl_active_i = 1'b1;
		hdr_chk = 1'b1;
		send_beat(16'd0, LOAD_ADDR[7:0]);
		send_beat(16'd1, LOAD_ADDR[15:8]);
		hdr_chk = 1'b0;
		in_data = 1'b1;
		for (int k = 0; k < NUM_BYTES; k++) begin
			if (k == STALL_AT) begin
				while (dl_wait_o) begin
					tick();
				end
				force_busy <= 1'b1;
				tick();
			end
			send_beat(16'(k + 2), dl_bytes[k]);
			if (k == STALL_AT) begin
				stall_chk = 1'b1;
				repeat (STALL_CYCLES) tick();
				stall_chk = 1'b0;
				force_busy <= 1'b0;
			end
		end
		while (dl_wait_o) begin
			tick();
		end
		dl_active_i = 1'b0;
		in_data = 1'b0;
		pass_chk <= 1'b0;
		repeat (3) tick();
		auto_chk = 1'b1;

		while (evt_count < 8) begin
			tick();
		end
		// Injector keeps one quiet step after the last release
		repeat (`LDR_KEY_STEP_CYCLES + 4) tick();
		auto_chk = 1'b0;
		pass_chk <= 1'b1;
		repeat (30) tick();
		pass_chk <= 1'b0;
		check_log();

		$display("Errors: protocol %0d, data %0d, keys %0d", proto_errs, data_errs, key_errs);
		if (proto_errs + data_errs + key_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/loader_pkg.sv
design/mem_write_port.sv
design/load_sequencer.sv
design/key_injector.sv
design/prg_loader_top.sv
sim/tb_prg_loader.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_prg_loader
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
